/* rtl/dotMacPkg.sv */
`default_nettype none

package dotMacPkg;

	// operand widths, x never wider than y
	localparam int widthX = 8;	// multiplier x0, x1
	localparam int widthY = 8;	// multiplicand y0, y1

	// one product in carry-save form
	localparam int widthP = widthX + widthY;

	// accumulator, at least two bits above one product
	localparam int widthA = 24;

	// baugh-wooley rows incl the two correction rows
	localparam int numPP = widthX + 2;

	// carry-propagate structure in prefixAdd
	localparam int adderSpeed = 2;	// 0 serial, 2 sklansky

endpackage

`default_nettype wire

/* rtl/ppGenSgn.sv */
`timescale 1ns/1ns
`default_nettype none

// signed partial products, baugh-wooley form
module ppGenSgn import dotMacPkg::*; (
	input  logic [widthX-1:0]       x,	// multiplier
	input  logic [widthY-1:0]       y,	// multiplicand
	output logic [numPP*widthP-1:0] pp	// rows of widthP, row 0 at lsb
);

	always_comb begin
		pp = '0;

		// rows for the non-sign bits of x
		for (int i = 0; i < widthX - 1; i++) begin
			for (int k = 0; k < widthY - 1; k++) begin
				pp[i*widthP + i + k] = x[i] & y[k];
			end
			pp[i*widthP + i + widthY - 1] = ~x[i] & y[widthY-1];	// meets sign of y
		end

		// row of the x sign bit, inverted against the low y bits
		for (int k = 0; k < widthY - 1; k++) begin
			pp[(widthX-1)*widthP + widthX - 1 + k] = x[widthX-1] & ~y[k];
		end
		pp[(widthX-1)*widthP + widthX + widthY - 2] = x[widthX-1] & y[widthY-1];

		// correction row for x
		pp[(numPP-2)*widthP + widthP - 2] = ~x[widthX-1];
		pp[(numPP-2)*widthP + widthX - 1] = x[widthX-1];

		// correction row for y plus the constant one at the msb
		pp[(numPP-1)*widthP + widthP - 1] = 1'b1;
		pp[(numPP-1)*widthP + widthP - 2] = ~y[widthY-1];
		pp[(numPP-1)*widthP + widthY - 1] = y[widthY-1];

		// unsigned sum of all rows is x*y mod 2^widthP
	end

endmodule

`default_nettype wire

/* rtl/csvTreeAdd.sv */
`timescale 1ns/1ns
`default_nettype none

// multi-operand carry-save adder
// one (depth,2) compressor per column, full adders in tree order
module csvTreeAdd #(
	parameter int depth = 4,	// operand count, 4 or more
	parameter int width = 8		// word width
) (
	input  logic [depth*width-1:0] ops,	// operand k at bits k*width
	output logic [width-1:0]       s,	// sum vector
	output logic [width-1:0]       c	// carry vector, already shifted
);

	// intermediate carries between column slices
	// slot i feeds column i, top slot leaves the word
	wire [(width+1)*(depth-3)-1:0] ic;
	wire [width-1:0] ct;	// column carries before the shift

	assign ic[depth-4:0] = '0;	// nothing enters column 0

	for (genvar i = 0; i < width; i++) begin : gCol
		// f holds inputs first, then fa sums and carry-ins appended
		wire [3*depth-6:0] f;
		wire [depth-3:0]   co;	// fa carries of this column

		// bits of equal weight from all operands
		for (genvar k = 0; k < depth; k++) begin : gIn
			assign f[k] = ops[k*width + i];
		end

		for (genvar j = 0; j < depth - 2; j++) begin : gFa
			// full adder j eats three entries of f
			assign f[depth + 2*j] = f[3*j] ^ f[3*j+1] ^ f[3*j+2];
			assign co[j] = (f[3*j] & f[3*j+1])
				| (f[3*j+2] & (f[3*j] ^ f[3*j+1]));

			// carry from the column below goes behind the sum
			if (j < depth - 3) begin : gCi
				assign f[depth + 2*j + 1] = ic[i*(depth-3) + j];
			end
		end

		// all but the last carry ripple into the next column
		assign ic[(i+1)*(depth-3) +: depth-3] = co[depth-4:0];

		assign s[i]  = f[3*depth-6];	// last fa sum
		assign ct[i] = co[depth-3];		// last fa carry
	end

	// carry weight is one column up, top carry wraps out
	assign c = {ct[width-2:0], 1'b0};

endmodule

`default_nettype wire

/* rtl/prefixAdd.sv */
`timescale 1ns/1ns
`default_nettype none

// carry-propagate adder on a parallel-prefix carry network
module prefixAdd import dotMacPkg::*; (
	input  logic [widthA-1:0] a,
	input  logic [widthA-1:0] b,
	output logic [widthA-1:0] sum	// a + b mod 2^widthA
);

	localparam int lvls = $clog2(widthA);	// sklansky depth

	logic [widthA-1:0] g;	// bit generate
	logic [widthA-1:0] p;	// bit propagate, also the half sum
	logic [widthA-1:0] gc;	// group generate over bits 0..i

	assign g = a & b;
	assign p = a ^ b;

	if (adderSpeed == 2) begin : gSklansky
		logic [lvls:0][widthA-1:0] gt;	// group generate per level
		logic [lvls:0][widthA-1:0] pt;	// group propagate per level

		always_comb begin
			int j;	// top bit of the lower half block

			gt[0] = g;
			pt[0] = p;
			for (int l = 1; l <= lvls; l++) begin
				gt[l] = gt[l-1];	// white nodes pass through
				pt[l] = pt[l-1];
				for (int i = 0; i < widthA; i++) begin
					// upper half of each 2^l block takes the lower half prefix
					if (((i >> (l-1)) & 1) == 1) begin
						j = ((i >> (l-1)) << (l-1)) - 1;
						gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][j]);
						pt[l][i] = pt[l-1][i] & pt[l-1][j];
					end
				end
			end
		end

		assign gc = gt[lvls];
	end else begin : gSerial
		logic [widthA-1:0] gt;	// rippled group generate

		always_comb begin
			gt[0] = g[0];
			for (int i = 1; i < widthA; i++) begin
				gt[i] = g[i] | (p[i] & gt[i-1]);	// one node per bit
			end
		end

		assign gc = gt;
	end

	// carry into bit i is the group generate of bits below it
	assign sum = p ^ {gc[widthA-2:0], 1'b0};

endmodule

`default_nettype wire

/* rtl/mulCsvLane.sv */
`timescale 1ns/1ns
`default_nettype none

// signed multiplier lane, product left in carry-save form
module mulCsvLane import dotMacPkg::*; (
	input  logic [widthX-1:0] x,
	input  logic [widthY-1:0] y,
	output logic [widthP-1:0] s,	// s + c mod 2^widthP is x*y
	output logic [widthP-1:0] c
);

	logic [numPP*widthP-1:0] pp;	// partial product rows

	ppGenSgn ppGen_i (
		.x (x),
		.y (y),
		.pp(pp)
	);

	// reduce all rows to two, carries stay unresolved
	csvTreeAdd #(
		.depth(numPP),
		.width(widthP)
	) ppTree_i (
		.ops(pp),
		.s  (s),
		.c  (c)
	);

endmodule

`default_nettype wire

/* rtl/dotMacCombine.sv */
`timescale 1ns/1ns
`default_nettype none

// merges both lanes with the accumulator, one cpa for the whole sum
module dotMacCombine import dotMacPkg::*; (
	input  logic              clk,
	input  logic              rstN,
	input  logic              inValid,	// take this cycle
	input  logic              clear,	// restart instead of accumulate
	input  logic [widthP-1:0] s0,		// lane 0 carry-save pair
	input  logic [widthP-1:0] c0,
	input  logic [widthP-1:0] s1,		// lane 1 carry-save pair
	input  logic [widthP-1:0] c1,
	output logic [widthA-1:0] acc,
	output logic              outValid
);

	logic [widthA-1:0] sExt0, cExt0;	// lane 0 at accumulator width
	logic [widthA-1:0] sExt1, cExt1;	// lane 1 at accumulator width
	logic [widthA-1:0] fb;				// accumulator feedback
	logic [5*widthA-1:0] ops;			// compressor operands
	logic [widthA-1:0] sumV, carV;		// compressor outputs
	logic [widthA-1:0] nextAcc;

	// sign extension of a carry-save pair
	// inverted msb above the sum vector, ones above the carry vector
	assign sExt0 = {{(widthA-widthP-1){1'b0}}, ~s0[widthP-1], s0};
	assign cExt0 = {{(widthA-widthP){1'b1}}, c0};
	assign sExt1 = {{(widthA-widthP-1){1'b0}}, ~s1[widthP-1], s1};
	assign cExt1 = {{(widthA-widthP){1'b1}}, c1};

	assign fb = clear ? '0 : acc;	// clear drops the old sum

	assign ops = {fb, cExt1, sExt1, cExt0, sExt0};

	// five operands down to two in one stage
	csvTreeAdd #(
		.depth(5),
		.width(widthA)
	) accTree_i (
		.ops(ops),
		.s  (sumV),
		.c  (carV)
	);

	prefixAdd cpa_i (
		.a  (sumV),
		.b  (carV),
		.sum(nextAcc)	// wraps mod 2^widthA
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acc      <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;	// result one cycle after accept
			if (inValid) begin
				acc <= nextAcc;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/dotMac.sv */
`timescale 1ns/1ns
`default_nettype none

// two-term signed dot-product accumulator
module dotMac import dotMacPkg::*; (
	input  logic              clk,
	input  logic              rstN,
	input  logic              inValid,
	input  logic              clear,
	input  logic [widthX-1:0] x0,
	input  logic [widthY-1:0] y0,
	input  logic [widthX-1:0] x1,
	input  logic [widthY-1:0] y1,
	output logic [widthA-1:0] acc,
	output logic              outValid
);

	logic [widthP-1:0] s0, c0;	// x0*y0, unresolved
	logic [widthP-1:0] s1, c1;	// x1*y1, unresolved

	mulCsvLane lane0 (.x(x0), .y(y0), .s(s0), .c(c0));

	mulCsvLane lane1 (.x(x1), .y(y1), .s(s1), .c(c1));

	dotMacCombine combine (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.clear   (clear),
		.s0      (s0),
		.c0      (c0),
		.s1      (s1),
		.c1      (c1),
		.acc     (acc),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

/* dv/dotMac_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

// reset and strobe properties of the combiner
module dotMac_assertions import dotMacPkg::*; (
	input logic              clk,
	input logic              rstN,
	input logic              inValid,
	input logic [widthA-1:0] acc,
	input logic              outValid
);

	// a reset edge leaves no pulse behind
	// the last reset edge covers the first cycle out of reset
	property pResetQuiet;
		@(posedge clk) !rstN |=> !outValid;
	endproperty

	property pValidFollows;
		@(posedge clk) disable iff (!rstN) rstN |=> (outValid == $past(inValid));
	endproperty

	// idle cycle must not touch the accumulator
	property pAccHold;
		@(posedge clk) disable iff (!rstN) !inValid |=> $stable(acc);
	endproperty

	aResetQuiet: assert property (pResetQuiet) else $error("outValid high after a reset cycle");
	aValidFollows: assert property (pValidFollows) else $error("outValid does not follow inValid");
	aAccHold: assert property (pAccHold) else $error("acc changed after an idle cycle");

endmodule

bind dotMacCombine dotMac_assertions assertions_i (
	.clk     (clk),
	.rstN    (rstN),
	.inValid (inValid),
	.acc     (acc),
	.outValid(outValid)
);

`default_nettype wire

/* dv/dotMacTb.sv */
`timescale 1ns/1ns
`default_nettype none

module dotMacTb import dotMacPkg::*; ();

	localparam int numDirected = 4;		// corner vectors
	localparam int numRandom   = 2000;	// random cycles with half near the wrap
	localparam int maxCycles   = 2 * (numDirected + numRandom);
	localparam logic [31:0] seed = 32'h0037ad3e;

	logic              clk;
	logic              rstN;
	logic              inValid;
	logic              clear;
	logic [widthX-1:0] x0;
	logic [widthY-1:0] y0;
	logic [widthX-1:0] x1;
	logic [widthY-1:0] y1;
	wire  [widthA-1:0] acc;
	wire               outValid;

	logic [31:0]       lfsr;		// stimulus state
	logic [widthA-1:0] modelAcc;	// what acc must show after the next edge
	logic              expValid;
	int                cycleCnt;
	int                wrapCnt;		// accumulator wraps seen by the model

	dotMac dut_i (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.clear   (clear),
		.x0      (x0),
		.y0      (y0),
		.x1      (x1),
		.y1      (y1),
		.acc     (acc),
		.outValid(outValid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt > maxCycles) begin
			reportFail($sformatf("timeout: run did not end within %0d cycles", maxCycles));
		end
	end

	// fibonacci lfsr on taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] st);
		logic fbBit;
		fbBit = st[31] ^ st[21] ^ st[1] ^ st[0];
		return {st[30:0], fbBit};
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);	// one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// signed products added to the old acc or to zero and wrapped at 2^widthA
	function automatic logic [widthA-1:0] nextModel(
		input logic [widthA-1:0]        old,
		input logic                     clr,
		input logic signed [widthX-1:0] a0,
		input logic signed [widthY-1:0] b0,
		input logic signed [widthX-1:0] a1,
		input logic signed [widthY-1:0] b1
	);
		int p0;
		int p1;
		logic [31:0] tot;
		p0 = int'(a0) * int'(b0);
		p1 = int'(a1) * int'(b1);
		tot = 32'(p0 + p1) + (clr ? 32'd0 : {{(32-widthA){1'b0}}, old});
		return tot[widthA-1:0];
	endfunction

	task automatic checkOutputs();
		assert (outValid === expValid) else begin
			reportFail($sformatf("CHECK FAILED outValid: got %h, expected %h", outValid, expValid));
		end
		assert (acc === modelAcc) else begin
			reportFail($sformatf("CHECK FAILED acc: got %h, expected %h", acc, modelAcc));
		end
	endtask

	// drive one cycle and check what the previous edge captured
	task automatic stepCycle(
		input logic              iv,
		input logic              clr,
		input logic [widthX-1:0] a0,
		input logic [widthY-1:0] b0,
		input logic [widthX-1:0] a1,
		input logic [widthY-1:0] b1
	);
		@(posedge clk);
		inValid <= iv;
		clear   <= clr;
		x0      <= a0;
		y0      <= b0;
		x1      <= a1;
		y1      <= b1;
		@(negedge clk);
		checkOutputs();
		expValid = iv;
		if (iv) begin
			modelAcc = nextModel(modelAcc, clr, a0, b0, a1, b1);
		end
	endtask

	task automatic runRandom(input int n);
		logic [31:0]       r;
		logic              iv;
		logic              clr;
		logic [widthX-1:0] a0;
		logic [widthY-1:0] b0;
		logic [widthX-1:0] a1;
		logic [widthY-1:0] b1;
		for (int i = 0; i < n; i++) begin
			randBits(2, r);
			iv = (r[1:0] != 2'b00);		// about 3/4
			randBits(3, r);
			clr = (r[2:0] == 3'b000);	// about 1/8
			randBits(widthX, r);
			a0 = r[widthX-1:0];
			randBits(widthY, r);
			b0 = r[widthY-1:0];
			randBits(widthX, r);
			a1 = r[widthX-1:0];
			randBits(widthY, r);
			b1 = r[widthY-1:0];
			stepCycle(iv, clr, a0, b0, a1, b1);
		end
	endtask

	// extreme operands without clear give positive products that push acc through the wrap
	task automatic runWrap(input int n);
		logic [31:0]       r;
		logic              iv;
		logic [widthX-1:0] op;
		logic [widthA-1:0] prev;
		for (int i = 0; i < n; i++) begin
			randBits(2, r);
			iv = (r[1:0] != 2'b00);
			randBits(1, r);
			op = r[0] ? 8'h80 : 8'h7f;	// -128 or 127 on all four
			prev = modelAcc;
			stepCycle(iv, 1'b0, op, op, op, op);
			if (modelAcc < prev) begin
				wrapCnt++;
			end
		end
	endtask

	initial begin
		lfsr     = seed;
		cycleCnt = 0;
		wrapCnt  = 0;
		rstN     = 1'b0;
		inValid  = 1'b0;
		clear    = 1'b0;
		x0       = '0;
		y0       = '0;
		x1       = '0;
		y1       = '0;
		modelAcc = '0;
		expValid = 1'b0;

		@(posedge clk);
		@(negedge clk);
		checkOutputs();		// still in reset
		@(posedge clk);
		rstN <= 1'b1;		// low for two edges
		stepCycle(1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00);

		// corner products that each start a new sum
		stepCycle(1'b1, 1'b1, 8'h80, 8'h80, 8'h80, 8'h7f);
		stepCycle(1'b1, 1'b1, 8'h00, 8'hff, 8'hff, 8'hff);
		stepCycle(1'b1, 1'b1, 8'hff, 8'h7f, 8'h7f, 8'h80);
		stepCycle(1'b1, 1'b1, 8'h80, 8'h80, 8'h80, 8'h80);

		runRandom(numRandom / 2);
		runWrap(numRandom / 2);
		stepCycle(1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00);	// collect the last result

		assert (wrapCnt > 0) else begin
			reportFail("the accumulator never wrapped during the extreme-operand run");
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
rtl/dotMacPkg.sv
rtl/ppGenSgn.sv
rtl/csvTreeAdd.sv
rtl/prefixAdd.sv
rtl/mulCsvLane.sv
rtl/dotMacCombine.sv
rtl/dotMac.sv
dv/dotMac_assertions.sv
dv/dotMacTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dotMacTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# simulator binary, rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
